// ==== periph_xbar_config.svh ====
// ----------------------------------------------------------
// Counts, widths and decode constants of the peripheral
// crossbar. Included by the package and every RTL file
// ----------------------------------------------------------
`ifndef PERIPH_XBAR_CONFIG_SVH
`define PERIPH_XBAR_CONFIG_SVH

// Initiators are the cores plus one master peripheral
`define PX_NB_INIT 4

// Slave peripherals on the crossbar
`define PX_NB_TGT 8
`define PX_TGT_IDX_W 3

// Bus widths
`define PX_DATA_W 32
`define PX_ADDR_W 32
`define PX_BE_W 4

// Address bits 31:24 of this cluster
`define PX_CLUSTER_BASE 8'h10

// Peripheral window spans regions 2 and 3
// Only region 2 holds decodable peripherals
`define PX_REGION_PERIPH 2
`define PX_REGION_LAST 3

// Event unit owns two plugs that fold into one target
`define PX_EU_FIRST 4
`define PX_EU_PLUGS 2

// Catch-all targets
`define PX_ERR_IDX 6
`define PX_EXT_IDX 7

`endif

// ==== periph_xbar_pkg.sv ====
// ----------------------------------------------------------
// Types shared by the peripheral crossbar and its testbench
// ----------------------------------------------------------
`default_nettype none

`include "periph_xbar_config.svh"

package periph_xbar_pkg;

  // Request address, used whole when forwarded and split
  // into fields by the initiator side decoder
  typedef union packed {
    logic [`PX_ADDR_W-1:0] raw;
    struct packed {
      // Cluster select, compared against the cluster base
      logic [7:0]  cluster;
      // Region inside the cluster
      logic [3:0]  region;
      // Peripheral number inside the region
      logic [3:0]  target;
      // Register offset, passed through untouched
      logic [15:0] offset;
    } fields;
  } pe_addr_u;

endpackage

`default_nettype wire

// ==== periph_xbar_if.sv ====
// ----------------------------------------------------------
// Request and response buses between the initiator ports
// and the per target arbiters of the peripheral crossbar
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

// One initiator's request, already steered to a single target
interface periph_req_if;

  // One bit per target, at most one high
  logic [`PX_NB_TGT-1:0]     tgt_req;
  // Each arbiter drives its own bit
  logic [`PX_NB_TGT-1:0]     tgt_gnt;

  periph_xbar_pkg::pe_addr_u addr;
  logic [`PX_DATA_W-1:0]     wdata;
  logic                      we_n;
  logic [`PX_BE_W-1:0]       be;
  // One-hot initiator id, echoed back in the response
  logic [`PX_NB_INIT-1:0]    id;

  modport port (
    output tgt_req,
    output addr,
    output wdata,
    output we_n,
    output be,
    output id,
    input  tgt_gnt
  );

  modport arb (
    input  tgt_req,
    input  addr,
    input  wdata,
    input  we_n,
    input  be,
    input  id,
    output tgt_gnt
  );

endinterface

// One target's response, valid for a single cycle
interface periph_resp_if;

  logic                   r_valid;
  logic [`PX_DATA_W-1:0]  r_rdata;
  logic [`PX_NB_INIT-1:0] r_id;
  logic                   r_opc;

  modport src (
    output r_valid,
    output r_rdata,
    output r_id,
    output r_opc
  );

  modport sink (
    input r_valid,
    input r_rdata,
    input r_id,
    input r_opc
  );

endinterface

`default_nettype wire

// ==== periph_initiator_port.sv ====
// ----------------------------------------------------------
// Initiator side of the crossbar. Decodes the address,
// steers the request and picks out this initiator's response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

module periph_initiator_port #(
  parameter int INIT_IDX = 0
) (
  input  logic                      req_i,
  input  periph_xbar_pkg::pe_addr_u addr_i,
  input  logic [`PX_DATA_W-1:0]     wdata_i,
  input  logic                      we_n_i,
  input  logic [`PX_BE_W-1:0]       be_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output logic [`PX_DATA_W-1:0]     r_rdata_o,
  output logic                      r_opc_o,
  periph_req_if.port                steer,
  periph_resp_if.sink               resp [`PX_NB_TGT]
);

  localparam int NI  = `PX_NB_INIT;
  localparam int NT  = `PX_NB_TGT;
  localparam int TIW = `PX_TGT_IDX_W;

  logic [TIW-1:0]               tgt_idx;
  logic [NI-1:0]                my_id;
  logic [NT-1:0]                hit;
  logic [NT-1:0][`PX_DATA_W-1:0] rdata_arr;
  logic [NT-1:0]                opc_arr;

  // Map an address onto a target index
  function automatic logic [TIW-1:0] decode_tgt(input periph_xbar_pkg::pe_addr_u addr);
    logic in_window;
    int   region;
    int   tgt;
    region    = int'(addr.fields.region);
    tgt       = int'(addr.fields.target);
    in_window = (addr.fields.cluster == `PX_CLUSTER_BASE) &&
                (region >= `PX_REGION_PERIPH) && (region <= `PX_REGION_LAST);
    if (!in_window) begin
      return TIW'(`PX_EXT_IDX);
    end
    if (region == `PX_REGION_PERIPH && tgt < NT) begin
      // Both event unit plugs land on the same port
      if (tgt >= `PX_EU_FIRST && tgt < `PX_EU_FIRST + `PX_EU_PLUGS) begin
        return TIW'(`PX_EU_FIRST);
      end
      return TIW'(tgt);
    end
    // Inside the window but no peripheral there
    return TIW'(`PX_ERR_IDX);
  endfunction

  assign tgt_idx = decode_tgt(addr_i);
  assign my_id   = NI'(1) << INIT_IDX;

  // Request steering
  assign steer.tgt_req = req_i ? (NT'(1) << tgt_idx) : '0;
  assign steer.addr    = addr_i;
  assign steer.wdata   = wdata_i;
  assign steer.we_n    = we_n_i;
  assign steer.be      = be_i;
  assign steer.id      = my_id;

  assign gnt_o = steer.tgt_gnt[tgt_idx];

  // Responses carrying our id, at most one per cycle
  for (genvar t = 0; t < NT; t++) begin : gen_resp_hit
    assign hit[t]       = resp[t].r_valid && (resp[t].r_id == my_id);
    assign rdata_arr[t] = resp[t].r_rdata;
    assign opc_arr[t]   = resp[t].r_opc;
  end

  assign r_valid_o = |hit;

  // AND-OR mux, the hit vector is one-hot or zero
  always_comb begin
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
    for (int t = 0; t < NT; t++) begin
      r_rdata_o = r_rdata_o | ({`PX_DATA_W{hit[t]}} & rdata_arr[t]);
      r_opc_o   = r_opc_o | (hit[t] & opc_arr[t]);
    end
  end

endmodule

`default_nettype wire

// ==== periph_rr_arbiter.sv ====
// ----------------------------------------------------------
// Round-robin arbiter for one target. Picks an initiator,
// forwards its payload and returns the grant to it alone
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

module periph_rr_arbiter #(
  parameter int TGT_IDX = 0
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  periph_req_if.arb              steer [`PX_NB_INIT],
  input  logic                   gnt_i,
  output logic                   req_o,
  output logic [`PX_ADDR_W-1:0]  addr_o,
  output logic [`PX_DATA_W-1:0]  wdata_o,
  output logic                   we_n_o,
  output logic [`PX_BE_W-1:0]    be_o,
  output logic [`PX_NB_INIT-1:0] id_o
);

  localparam int NI = `PX_NB_INIT;
  localparam int IW = $clog2(NI);

  logic [NI-1:0]                 reqs;
  logic [NI-1:0][`PX_ADDR_W-1:0] addr_arr;
  logic [NI-1:0][`PX_DATA_W-1:0] wdata_arr;
  logic [NI-1:0]                 we_n_arr;
  logic [NI-1:0][`PX_BE_W-1:0]   be_arr;
  logic [NI-1:0][NI-1:0]         id_arr;

  // Priority pointer, first initiator to look at
  logic [IW-1:0] ptr;
  logic [IW-1:0] winner;
  logic [IW-1:0] cand;
  logic          found;
  // Winner is frozen while the target stalls
  logic          locked;
  logic [IW-1:0] lock_idx;

  for (genvar j = 0; j < NI; j++) begin : gen_gather
    assign reqs[j]      = steer[j].tgt_req[TGT_IDX];
    assign addr_arr[j]  = steer[j].addr.raw;
    assign wdata_arr[j] = steer[j].wdata;
    assign we_n_arr[j]  = steer[j].we_n;
    assign be_arr[j]    = steer[j].be;
    assign id_arr[j]    = steer[j].id;
    assign steer[j].tgt_gnt[TGT_IDX] = req_o & gnt_i & (winner == IW'(j));
  end

  // Scan from the pointer and wrap around
  always_comb begin
    winner = ptr;
    found  = 1'b0;
    cand   = ptr;
    for (int k = 0; k < NI; k++) begin
      cand = ptr + IW'(k);
      if (!found && reqs[cand]) begin
        winner = cand;
        found  = 1'b1;
      end
    end
    if (locked) begin
      winner = lock_idx;
    end
  end

  assign req_o   = |reqs;
  assign addr_o  = addr_arr[winner];
  assign wdata_o = wdata_arr[winner];
  assign we_n_o  = we_n_arr[winner];
  assign be_o    = be_arr[winner];
  assign id_o    = id_arr[winner];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr      <= '0;
      locked   <= 1'b0;
      lock_idx <= '0;
    end else begin
      locked   <= req_o & ~gnt_i;
      lock_idx <= winner;
      // Move past the winner once the transfer happens
      if (req_o && gnt_i) begin
        ptr <= winner + IW'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== periph_xbar.sv ====
// ----------------------------------------------------------
// Peripheral crossbar top level. Four initiators reach eight
// targets, with a round-robin arbiter in front of each target
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

module periph_xbar (
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  // Initiator side
  input  logic [`PX_NB_INIT-1:0]                        init_req_i,
  input  periph_xbar_pkg::pe_addr_u [`PX_NB_INIT-1:0]   init_addr_i,
  input  logic [`PX_NB_INIT-1:0][`PX_DATA_W-1:0]        init_wdata_i,
  input  logic [`PX_NB_INIT-1:0]                        init_we_n_i,
  input  logic [`PX_NB_INIT-1:0][`PX_BE_W-1:0]          init_be_i,
  output logic [`PX_NB_INIT-1:0]                        init_gnt_o,
  output logic [`PX_NB_INIT-1:0]                        init_r_valid_o,
  output logic [`PX_NB_INIT-1:0][`PX_DATA_W-1:0]        init_r_rdata_o,
  output logic [`PX_NB_INIT-1:0]                        init_r_opc_o,

  // Target side
  output logic [`PX_NB_TGT-1:0]                         tgt_req_o,
  output logic [`PX_NB_TGT-1:0][`PX_ADDR_W-1:0]         tgt_addr_o,
  output logic [`PX_NB_TGT-1:0][`PX_DATA_W-1:0]         tgt_wdata_o,
  output logic [`PX_NB_TGT-1:0]                         tgt_we_n_o,
  output logic [`PX_NB_TGT-1:0][`PX_BE_W-1:0]           tgt_be_o,
  output logic [`PX_NB_TGT-1:0][`PX_NB_INIT-1:0]        tgt_id_o,
  input  logic [`PX_NB_TGT-1:0]                         tgt_gnt_i,
  input  logic [`PX_NB_TGT-1:0]                         tgt_r_valid_i,
  input  logic [`PX_NB_TGT-1:0][`PX_DATA_W-1:0]         tgt_r_rdata_i,
  input  logic [`PX_NB_TGT-1:0][`PX_NB_INIT-1:0]        tgt_r_id_i,
  input  logic [`PX_NB_TGT-1:0]                         tgt_r_opc_i
);

  localparam int NI = `PX_NB_INIT;
  localparam int NT = `PX_NB_TGT;

  // Steered requests, one bus per initiator
  periph_req_if  req_bus [NI] ();
  // Responses, one bus per target
  periph_resp_if resp_bus [NT] ();

  for (genvar t = 0; t < NT; t++) begin : gen_resp
    assign resp_bus[t].r_valid = tgt_r_valid_i[t];
    assign resp_bus[t].r_rdata = tgt_r_rdata_i[t];
    assign resp_bus[t].r_id    = tgt_r_id_i[t];
    assign resp_bus[t].r_opc   = tgt_r_opc_i[t];
  end

  // Decode and response selection per initiator
  for (genvar i = 0; i < NI; i++) begin : gen_init
    periph_initiator_port #(
      .INIT_IDX (i)
    ) u_init_port (
      .req_i     (init_req_i[i]),
      .addr_i    (init_addr_i[i]),
      .wdata_i   (init_wdata_i[i]),
      .we_n_i    (init_we_n_i[i]),
      .be_i      (init_be_i[i]),
      .gnt_o     (init_gnt_o[i]),
      .r_valid_o (init_r_valid_o[i]),
      .r_rdata_o (init_r_rdata_o[i]),
      .r_opc_o   (init_r_opc_o[i]),
      .steer     (req_bus[i]),
      .resp      (resp_bus)
    );
  end

  // Arbitration per target
  for (genvar t = 0; t < NT; t++) begin : gen_tgt
    periph_rr_arbiter #(
      .TGT_IDX (t)
    ) u_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .steer   (req_bus),
      .gnt_i   (tgt_gnt_i[t]),
      .req_o   (tgt_req_o[t]),
      .addr_o  (tgt_addr_o[t]),
      .wdata_o (tgt_wdata_o[t]),
      .we_n_o  (tgt_we_n_o[t]),
      .be_o    (tgt_be_o[t]),
      .id_o    (tgt_id_o[t])
    );
  end

endmodule

`default_nettype wire

// ==== periph_xbar_chk.sv ====
// ----------------------------------------------------------
// Handshake assertions for the peripheral crossbar, bound
// onto the top level by the bind statement below
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

module periph_xbar_chk (
  input wire logic                                   clk_i,
  input wire logic                                   reset_i,
  input wire logic [`PX_NB_INIT-1:0]                 init_req_i,
  input wire logic [`PX_NB_INIT-1:0]                 init_gnt_o,
  input wire logic [`PX_NB_INIT-1:0]                 init_r_valid_o,
  input wire logic [`PX_NB_TGT-1:0]                  tgt_req_o,
  input wire logic [`PX_NB_TGT-1:0]                  tgt_gnt_i,
  input wire logic [`PX_NB_TGT-1:0][`PX_NB_INIT-1:0] tgt_id_o
);

  logic [`PX_NB_INIT-1:0] xfer_hit;

  // Initiators that own a transfer at some target this cycle
  always_comb begin
    xfer_hit = '0;
    for (int t = 0; t < `PX_NB_TGT; t++) begin
      if (tgt_req_o[t] && tgt_gnt_i[t]) begin
        xfer_hit = xfer_hit | tgt_id_o[t];
      end
    end
  end

  // Each transfer grants a single initiator
  a_one_winner: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones(init_gnt_o) <= $countones(tgt_req_o & tgt_gnt_i))
    else $error("more initiators granted than transfers taking place");

  for (genvar i = 0; i < `PX_NB_INIT; i++) begin : gen_init_chk
    a_gnt_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
      init_gnt_o[i] |-> (init_req_i[i] && xfer_hit[i]))
      else $error("initiator %0d granted without a matching transfer", i);
  end

  a_idle_after_reset: assert property (@(posedge clk_i)
    ($fell(reset_i) && init_req_i == '0) |->
      (tgt_req_o == '0 && init_gnt_o == '0 && init_r_valid_o == '0))
    else $error("outputs active right after reset with no request");

endmodule

bind periph_xbar periph_xbar_chk u_chk (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .init_req_i     (init_req_i),
  .init_gnt_o     (init_gnt_o),
  .init_r_valid_o (init_r_valid_o),
  .tgt_req_o      (tgt_req_o),
  .tgt_gnt_i      (tgt_gnt_i),
  .tgt_id_o       (tgt_id_o)
);

`default_nettype wire

// ==== periph_xbar_tb.sv ====
// ----------------------------------------------------------
// Testbench for the peripheral crossbar. Applies a table of
// requests, models the eight targets and checks every result
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "periph_xbar_config.svh"

module periph_xbar_tb;

  localparam int NI  = `PX_NB_INIT;
  localparam int NT  = `PX_NB_TGT;
  localparam int NR  = 9;
  localparam int TMO = 60;

  logic clk_i;
  logic reset_i;
  logic [NI-1:0]                            init_req_i;
  periph_xbar_pkg::pe_addr_u [NI-1:0]       init_addr_i;
  logic [NI-1:0][`PX_DATA_W-1:0]            init_wdata_i;
  logic [NI-1:0]                            init_we_n_i;
  logic [NI-1:0][`PX_BE_W-1:0]              init_be_i;
  logic [NI-1:0]                            init_gnt_o;
  logic [NI-1:0]                            init_r_valid_o;
  logic [NI-1:0][`PX_DATA_W-1:0]            init_r_rdata_o;
  logic [NI-1:0]                            init_r_opc_o;
  logic [NT-1:0]                            tgt_req_o;
  logic [NT-1:0][`PX_ADDR_W-1:0]            tgt_addr_o;
  logic [NT-1:0][`PX_DATA_W-1:0]            tgt_wdata_o;
  logic [NT-1:0]                            tgt_we_n_o;
  logic [NT-1:0][`PX_BE_W-1:0]              tgt_be_o;
  logic [NT-1:0][NI-1:0]                    tgt_id_o;
  logic [NT-1:0]                            tgt_gnt_i;
  logic [NT-1:0]                            tgt_r_valid_i;
  logic [NT-1:0][`PX_DATA_W-1:0]            tgt_r_rdata_i;
  logic [NT-1:0][NI-1:0]                    tgt_r_id_i;
  logic [NT-1:0]                            tgt_r_opc_i;

  // Stimulus table
  string      row_name [NR];
  logic [3:0] row_mask [NR];
  logic [7:0] row_stall [NR];
  logic [15:0] row_hi [NR][NI];
  logic [2:0] row_exp [NR][NI];

  // State of the row in flight and what the targets saw
  logic [NT-1:0] cur_stall;
  logic [2:0]    cur_exp [NI];
  logic [1:0]    rr_ptr [NT];
  int            stall_cnt [NT];
  logic [2:0]    got_tgt [NI];
  periph_xbar_pkg::pe_addr_u got_addr [NI];
  logic [`PX_DATA_W-1:0] got_wdata [NI];
  logic [`PX_BE_W+NI:0]  got_ctrl [NI];
  logic [`PX_DATA_W-1:0] rsp_data [NI];
  int            gnt_cyc [NI];

  periph_xbar periph_xbar_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Targets grant at once unless stalled, stalled ones wait three cycles
  for (genvar t = 0; t < NT; t++) begin : gen_gnt
    assign tgt_gnt_i[t] = tgt_req_o[t] && (!cur_stall[t] || stall_cnt[t] >= 3);
  end

  // Response side starts idle
  initial begin
    tgt_r_valid_i <= '0;
    tgt_r_rdata_i <= '0;
    tgt_r_id_i    <= '0;
    tgt_r_opc_i   <= '0;
  end

  always @(posedge clk_i) begin
    for (int t = 0; t < NT; t++) begin
      if (reset_i) begin
        tgt_r_valid_i[t] <= 1'b0;
        stall_cnt[t]     <= 0;
      end else begin
        tgt_r_valid_i[t] <= tgt_req_o[t] && tgt_gnt_i[t];
        tgt_r_id_i[t]    <= tgt_id_o[t];
        // Idle cycles show a stray opc of 1 that must stay hidden
        tgt_r_opc_i[t]   <= !(tgt_req_o[t] && tgt_gnt_i[t]);
        tgt_r_rdata_i[t] <= tgt_addr_o[t] ^ `PX_DATA_W'(t);
        if (tgt_req_o[t] && tgt_gnt_i[t]) begin
          stall_cnt[t] <= 0;
          for (int i = 0; i < NI; i++) begin
            if (tgt_id_o[t][i]) begin
              got_tgt[i]   <= 3'(t);
              got_addr[i]  <= periph_xbar_pkg::pe_addr_u'(tgt_addr_o[t]);
              got_wdata[i] <= tgt_wdata_o[t];
              got_ctrl[i]  <= {tgt_we_n_o[t], tgt_be_o[t], tgt_id_o[t]};
            end
          end
        end else if (tgt_req_o[t] && cur_stall[t]) begin
          stall_cnt[t] <= stall_cnt[t] + 1;
        end
      end
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_target(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (exp !== act) begin
      $display("Fail %s: target expected %0d actual %0d", name, exp, act);
      abort_run("wrong target index");
    end
  endtask

  task automatic check_addr(input string name, input periph_xbar_pkg::pe_addr_u exp,
                            input periph_xbar_pkg::pe_addr_u act);
    if (exp.raw !== act.raw) begin
      $display("Fail %s: addr expected %h actual %h", name, exp.raw, act.raw);
      abort_run("wrong address");
    end
  endtask

  task automatic check_rdata(input string name, input logic [`PX_DATA_W-1:0] exp,
                             input logic [`PX_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("Fail %s: data expected %h actual %h", name, exp, act);
      abort_run("wrong data word");
    end
  endtask

  task automatic check_opc(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s: opc expected %0d actual %0d", name, exp, act);
      abort_run("wrong response opcode");
    end
  endtask

  task automatic check_ctrl(input string name, input logic [`PX_BE_W+NI:0] exp,
                            input logic [`PX_BE_W+NI:0] act);
    if (exp !== act) begin
      $display("Fail %s: we_n/be/id expected %h actual %h", name, exp, act);
      abort_run("wrong control fields");
    end
  endtask

  task automatic check_initiator(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("Fail %s: winner expected %0d actual %0d", name, exp, act);
      abort_run("wrong arbitration winner");
    end
  endtask

  task automatic set_row(input int r, input string n, input logic [3:0] m, input logic [7:0] s,
                         input logic [15:0] a0, input logic [15:0] a1,
                         input logic [15:0] a2, input logic [15:0] a3,
                         input logic [2:0] e0, input logic [2:0] e1,
                         input logic [2:0] e2, input logic [2:0] e3);
    row_name[r]  = n;
    row_mask[r]  = m;
    row_stall[r] = s;
    row_hi[r][0] = a0;
    row_hi[r][1] = a1;
    row_hi[r][2] = a2;
    row_hi[r][3] = a3;
    row_exp[r][0] = e0;
    row_exp[r][1] = e1;
    row_exp[r][2] = e2;
    row_exp[r][3] = e3;
  endtask

  // First pending requester of target t, scanning from its pointer
  function automatic int exp_winner(input logic [2:0] t, input logic [NI-1:0] pend);
    int c;
    for (int k = 0; k < NI; k++) begin
      c = (int'(rr_ptr[t]) + k) % NI;
      if (pend[c] && cur_exp[c] == t) begin
        return c;
      end
    end
    return -1;
  endfunction

  task automatic run_row(input int r);
    logic [NI-1:0] pend_gnt;
    logic [NI-1:0] await_rsp;
    logic [NI-1:0] pend_snap;
    bit indep;
    int cyc;
    int w;
    indep = 1;
    for (int i = 0; i < NI; i++) begin
      cur_exp[i] = row_exp[r][i];
      if (row_mask[r][i] && row_stall[r][row_exp[r][i]]) indep = 0;
      for (int j = i + 1; j < NI; j++) begin
        if (row_mask[r][i] && row_mask[r][j] && row_exp[r][i] == row_exp[r][j]) indep = 0;
      end
    end
    cur_stall = row_stall[r];
    for (int i = 0; i < NI; i++) begin
      if (row_mask[r][i]) begin
        init_addr_i[i]  = {row_hi[r][i], 16'($urandom)};
        init_wdata_i[i] = $urandom;
        init_we_n_i[i]  = 1'($urandom);
        init_be_i[i]    = 4'($urandom);
        init_req_i[i]   = 1'b1;
      end
    end
    pend_gnt  = row_mask[r];
    await_rsp = '0;
    cyc = 0;
    while ((pend_gnt | await_rsp) != '0) begin
      @(posedge clk_i);
      cyc++;
      if (cyc > TMO) abort_run("Timeout waiting for a grant or a response");
      pend_snap = pend_gnt;
      for (int i = 0; i < NI; i++) begin
        if (init_r_valid_o[i]) begin
          if (!await_rsp[i]) abort_run("A response reached an initiator with nothing outstanding");
          check_opc({row_name[r], "_opc"}, 1'b0, init_r_opc_o[i]);
          rsp_data[i]  = init_r_rdata_o[i];
          await_rsp[i] = 1'b0;
        end
      end
      // Payload at a stalled target must hold still
      for (int t = 0; t < NT; t++) begin
        w = exp_winner(3'(t), pend_snap);
        if (cur_stall[t] && w >= 0) begin
          check_addr({row_name[r], "_stall"}, init_addr_i[w],
                     periph_xbar_pkg::pe_addr_u'(tgt_addr_o[t]));
        end
      end
      for (int i = 0; i < NI; i++) begin
        if (pend_snap[i] && init_gnt_o[i]) begin
          if (cur_stall[cur_exp[i]] && stall_cnt[cur_exp[i]] < 3) begin
            abort_run("An initiator was granted while its target stalled");
          end
          w = exp_winner(cur_exp[i], pend_snap);
          check_initiator({row_name[r], "_order"}, 2'(w), 2'(i));
          rr_ptr[cur_exp[i]] = 2'(i + 1);
          pend_gnt[i]  = 1'b0;
          await_rsp[i] = 1'b1;
          gnt_cyc[i]   = cyc;
        end
      end
      #1;
      init_req_i = init_req_i & pend_gnt;
    end
    cur_stall = '0;
    for (int i = 0; i < NI; i++) begin
      if (row_mask[r][i]) begin
        if (indep && gnt_cyc[i] != 1) abort_run("Independent requests were not granted together");
        check_target(row_name[r], row_exp[r][i], got_tgt[i]);
        check_addr(row_name[r], init_addr_i[i], got_addr[i]);
        check_rdata(row_name[r], init_wdata_i[i], got_wdata[i]);
        check_ctrl(row_name[r], {init_we_n_i[i], init_be_i[i], NI'(1) << i}, got_ctrl[i]);
        check_rdata({row_name[r], "_rsp"}, init_addr_i[i].raw ^ `PX_DATA_W'(row_exp[r][i]),
                    rsp_data[i]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h1299));
    reset_i      = 1'b1;
    init_req_i   = '0;
    init_addr_i  = '0;
    init_wdata_i = '0;
    init_we_n_i  = '1;
    init_be_i    = '0;
    cur_stall    = '0;
    for (int t = 0; t < NT; t++) rr_ptr[t] = 2'd0;
    // Address upper halves are cluster, region and target field
    set_row(0, "decode_periph", 4'hf, 8'h00, 16'h1020, 16'h1021, 16'h1022, 16'h1023, 0, 1, 2, 3);
    set_row(1, "decode_eu_err", 4'hf, 8'h00, 16'h1025, 16'h1026, 16'h1027, 16'h1030, 4, 6, 7, 6);
    set_row(2, "decode_ext", 4'hf, 8'h00, 16'h1120, 16'h1010, 16'h1040, 16'h1029, 7, 7, 7, 6);
    set_row(3, "eu_fold", 4'h1, 8'h00, 16'h1024, 16'h0, 16'h0, 16'h0, 4, 0, 0, 0);
    set_row(4, "rr_first", 4'hf, 8'h00, 16'h1023, 16'h1023, 16'h1023, 16'h1023, 3, 3, 3, 3);
    // A lone winner at target 3 moves its pointer to initiator 2
    set_row(5, "rr_shift", 4'h2, 8'h00, 16'h0, 16'h1023, 16'h0, 16'h0, 0, 3, 0, 0);
    set_row(6, "rr_second", 4'hf, 8'h00, 16'h1023, 16'h1023, 16'h1023, 16'h1023, 3, 3, 3, 3);
    set_row(7, "stall", 4'h3, 8'h04, 16'h1020, 16'h1022, 16'h0, 16'h0, 0, 2, 0, 0);
    set_row(8, "independent", 4'hf, 8'h00, 16'h1020, 16'h1025, 16'h1022, 16'h2000, 0, 4, 2, 7);
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    for (int r = 0; r < NR; r++) begin
      run_row(r);
      @(posedge clk_i);
      #1;
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== periph_xbar.f ====
+incdir+.
periph_xbar_pkg.sv
periph_xbar_if.sv
periph_initiator_port.sv
periph_rr_arbiter.sv
periph_xbar.sv
periph_xbar_chk.sv
periph_xbar_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the peripheral crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f periph_xbar.f \
  --top-module periph_xbar_tb \
  -o periph_xbar_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/periph_xbar_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
